// File: hdl/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define MIPS_WORD_W      32
`define MIPS_REG_ADDR_W  5
`define MIPS_REG_NUM     32
`define MIPS_ALU_OP_W    5

// Primary opcodes
`define MIPS_OP_SPECIAL  6'b000000
`define MIPS_OP_ADDIU    6'b001001
`define MIPS_OP_SLTI     6'b001010
`define MIPS_OP_SLTIU    6'b001011
`define MIPS_OP_ANDI     6'b001100
`define MIPS_OP_ORI      6'b001101
`define MIPS_OP_XORI     6'b001110
`define MIPS_OP_LUI      6'b001111

// SPECIAL function field
`define MIPS_FN_SLL      6'b000000
`define MIPS_FN_SRL      6'b000010
`define MIPS_FN_SRA      6'b000011
`define MIPS_FN_SLLV     6'b000100
`define MIPS_FN_SRLV     6'b000110
`define MIPS_FN_SRAV     6'b000111
`define MIPS_FN_ADDU     6'b100001
`define MIPS_FN_SUBU     6'b100011
`define MIPS_FN_AND      6'b100100
`define MIPS_FN_OR       6'b100101
`define MIPS_FN_XOR      6'b100110
`define MIPS_FN_NOR      6'b100111
`define MIPS_FN_SLT      6'b101010
`define MIPS_FN_SLTU     6'b101011

// ALU operations
`define MIPS_ALU_NOP     5'd0
`define MIPS_ALU_OR      5'd1
`define MIPS_ALU_AND     5'd2
`define MIPS_ALU_XOR     5'd3
`define MIPS_ALU_NOR     5'd4
`define MIPS_ALU_ADD     5'd5
`define MIPS_ALU_SUB     5'd6
`define MIPS_ALU_SLT     5'd7
`define MIPS_ALU_SLTU    5'd8
`define MIPS_ALU_SLL     5'd9
`define MIPS_ALU_SRL     5'd10
`define MIPS_ALU_SRA     5'd11

`endif

// File: hdl/mips_isa_pkg.sv
`include "mips_defs.svh"

package mips_isa_pkg;

	typedef logic [`MIPS_WORD_W-1:0] word_t;
	typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

	typedef logic [31:0] inst_t; // Raw instruction word

	// Instruction fields
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] shamt_t;
	typedef logic [15:0] imm16_t;

endpackage

// File: hdl/mips_pipe_pkg.sv
`include "mips_defs.svh"

package mips_pipe_pkg;
	import mips_isa_pkg::*;

	typedef logic [`MIPS_ALU_OP_W-1:0] alu_op_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic reg1_read;
		logic reg2_read;
		reg_addr_t reg1_addr;
		reg_addr_t reg2_addr;
		reg_addr_t wd;
		logic wreg;
		logic illegal;
		word_t imm;
	} dec_t;

	typedef struct packed {
		alu_op_t alu_op;
		word_t reg1;
		word_t reg2;
		reg_addr_t wd;
		logic wreg;
		logic illegal;
	} id_ex_t;

	typedef struct packed {
		logic wreg;
		reg_addr_t wd;
		word_t wdata;
	} fwd_t;

	typedef struct packed {
		logic wreg;
		reg_addr_t wd;
		word_t wdata;
		logic illegal;
	} result_t;

endpackage

// File: hdl/inst_decoder.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module inst_decoder
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
(
	input inst_t inst_i,
	output dec_t dec_o
);

	opcode_t op;
	funct_t fn;
	shamt_t sa;
	imm16_t imm16;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t imm_zext;
	word_t imm_sext;
	word_t imm_upper;
	word_t imm_shamt;
	logic legal;
	logic i_type;
	logic shift_imm;

	assign op = inst_i[31:26];
	assign rs = inst_i[25:21];
	assign rt = inst_i[20:16];
	assign rd = inst_i[15:11];
	assign sa = inst_i[10:6];
	assign fn = inst_i[5:0];
	assign imm16 = inst_i[15:0];

	assign imm_zext = {16'h0000, imm16};
	assign imm_sext = {{16{imm16[15]}}, imm16};
	assign imm_upper = {imm16, 16'h0000};
	assign imm_shamt = {{(`MIPS_WORD_W-5){1'b0}}, sa};

	always_comb begin
		dec_o = '0;
		dec_o.alu_op = `MIPS_ALU_NOP;
		dec_o.reg1_addr = rs;
		dec_o.reg2_addr = rt;
		dec_o.wd = rd;
		legal = 1'b0;
		i_type = 1'b0;
		shift_imm = 1'b0;

		case (op)
			`MIPS_OP_SPECIAL: begin
				dec_o.reg1_read = 1'b1;
				dec_o.reg2_read = 1'b1;
				legal = (sa == '0); // Register forms need a zero shift field
				case (fn)
					`MIPS_FN_OR:   dec_o.alu_op = `MIPS_ALU_OR;
					`MIPS_FN_AND:  dec_o.alu_op = `MIPS_ALU_AND;
					`MIPS_FN_XOR:  dec_o.alu_op = `MIPS_ALU_XOR;
					`MIPS_FN_NOR:  dec_o.alu_op = `MIPS_ALU_NOR;
					`MIPS_FN_ADDU: dec_o.alu_op = `MIPS_ALU_ADD;
					`MIPS_FN_SUBU: dec_o.alu_op = `MIPS_ALU_SUB;
					`MIPS_FN_SLT:  dec_o.alu_op = `MIPS_ALU_SLT;
					`MIPS_FN_SLTU: dec_o.alu_op = `MIPS_ALU_SLTU;
					`MIPS_FN_SLLV: dec_o.alu_op = `MIPS_ALU_SLL;
					`MIPS_FN_SRLV: dec_o.alu_op = `MIPS_ALU_SRL;
					`MIPS_FN_SRAV: dec_o.alu_op = `MIPS_ALU_SRA;
					`MIPS_FN_SLL: begin
						shift_imm = 1'b1;
						dec_o.alu_op = `MIPS_ALU_SLL;
					end
					`MIPS_FN_SRL: begin
						shift_imm = 1'b1;
						dec_o.alu_op = `MIPS_ALU_SRL;
					end
					`MIPS_FN_SRA: begin
						shift_imm = 1'b1;
						dec_o.alu_op = `MIPS_ALU_SRA;
					end
					default: legal = 1'b0;
				endcase
			end
			`MIPS_OP_ORI: begin
				i_type = 1'b1;
				dec_o.alu_op = `MIPS_ALU_OR;
				dec_o.imm = imm_zext;
			end
			`MIPS_OP_ANDI: begin
				i_type = 1'b1;
				dec_o.alu_op = `MIPS_ALU_AND;
				dec_o.imm = imm_zext;
			end
			`MIPS_OP_XORI: begin
				i_type = 1'b1;
				dec_o.alu_op = `MIPS_ALU_XOR;
				dec_o.imm = imm_zext;
			end
			`MIPS_OP_LUI: begin
				i_type = 1'b1;
				dec_o.alu_op = `MIPS_ALU_OR;
				dec_o.imm = imm_upper;
			end
			`MIPS_OP_ADDIU: begin
				i_type = 1'b1;
				dec_o.alu_op = `MIPS_ALU_ADD;
				dec_o.imm = imm_sext;
			end
			`MIPS_OP_SLTI: begin
				i_type = 1'b1;
				dec_o.alu_op = `MIPS_ALU_SLT;
				dec_o.imm = imm_sext;
			end
			`MIPS_OP_SLTIU: begin
				i_type = 1'b1;
				dec_o.alu_op = `MIPS_ALU_SLTU;
				dec_o.imm = imm_sext;
			end
			default: legal = 1'b0;
		endcase

		if (shift_imm) begin
			legal = (rs == '0);
			dec_o.reg1_read = 1'b0; // Shift amount comes from shamt
			dec_o.imm = imm_shamt;
		end

		if (i_type) begin
			legal = 1'b1;
			// LUI ORs the immediate with itself
			dec_o.reg1_read = (op != `MIPS_OP_LUI);
			dec_o.reg2_read = 1'b0;
			dec_o.wd = rt;
		end

		if (!legal) begin
			dec_o.alu_op = `MIPS_ALU_NOP;
		end
		dec_o.illegal = !legal;
		dec_o.wreg = legal && (dec_o.wd != '0); // r0 is never written
	end

endmodule

// File: hdl/id_stage.sv
`timescale 1ns/100ps

module id_stage
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
(
	input logic clk_i,
	input logic reset_i,
	input logic advance_i,
	input logic inst_valid_i,
	input inst_t inst_i,
	input fwd_t ex_fwd_i,
	input fwd_t wb_fwd_i,
	output reg_addr_t rd1_addr_o,
	output reg_addr_t rd2_addr_o,
	input word_t rd1_data_i,
	input word_t rd2_data_i,
	output logic id_ex_valid_o,
	output id_ex_t id_ex_o
);

	dec_t dec;
	id_ex_t id_ex_next;

	// Youngest producer wins, then the older one, then the register file
	function automatic word_t pick_operand(input logic rd_en, input reg_addr_t addr,
		input word_t rf_data, input word_t imm, input fwd_t ex_fwd, input fwd_t wb_fwd);
		word_t val;
		if (!rd_en) begin
			val = imm;
		end else if (ex_fwd.wreg && ex_fwd.wd == addr) begin
			val = ex_fwd.wdata;
		end else if (wb_fwd.wreg && wb_fwd.wd == addr) begin
			val = wb_fwd.wdata;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	inst_decoder u_dec (
		.inst_i(inst_i),
		.dec_o(dec)
	);

	assign rd1_addr_o = dec.reg1_addr;
	assign rd2_addr_o = dec.reg2_addr;

	always_comb begin
		id_ex_next.alu_op = dec.alu_op;
		id_ex_next.reg1 = pick_operand(dec.reg1_read, dec.reg1_addr, rd1_data_i, dec.imm,
			ex_fwd_i, wb_fwd_i);
		id_ex_next.reg2 = pick_operand(dec.reg2_read, dec.reg2_addr, rd2_data_i, dec.imm,
			ex_fwd_i, wb_fwd_i);
		id_ex_next.wd = dec.wd;
		id_ex_next.wreg = dec.wreg;
		id_ex_next.illegal = dec.illegal;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			id_ex_valid_o <= 1'b0;
		end else if (advance_i) begin
			id_ex_valid_o <= inst_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (advance_i) begin
			id_ex_o <= id_ex_next;
		end
	end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module reg_file
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
(
	input logic clk_i,
	input logic reset_i,
	input fwd_t wr_i,
	input reg_addr_t rd1_addr_i,
	input reg_addr_t rd2_addr_i,
	output word_t rd1_data_o,
	output word_t rd2_data_o
);

	word_t regs [`MIPS_REG_NUM];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < `MIPS_REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_i.wreg) begin
			regs[wr_i.wd] <= wr_i.wdata;
		end
	end

	assign rd1_data_o = regs[rd1_addr_i]; // Async read
	assign rd2_data_o = regs[rd2_addr_i];

endmodule

// File: hdl/ex_stage.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module ex_stage
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
(
	input logic id_ex_valid_i,
	input id_ex_t id_ex_i,
	output fwd_t ex_fwd_o,
	output logic ex_valid_o,
	output result_t ex_result_o
);

	word_t a;
	word_t b;
	word_t alu_y;
	logic [4:0] sh;

	assign a = id_ex_i.reg1;
	assign b = id_ex_i.reg2;
	assign sh = a[4:0]; // Shift count from operand 1

	always_comb begin
		case (id_ex_i.alu_op)
			`MIPS_ALU_OR:   alu_y = a | b;
			`MIPS_ALU_AND:  alu_y = a & b;
			`MIPS_ALU_XOR:  alu_y = a ^ b;
			`MIPS_ALU_NOR:  alu_y = ~(a | b);
			`MIPS_ALU_ADD:  alu_y = a + b;
			`MIPS_ALU_SUB:  alu_y = a - b;
			`MIPS_ALU_SLT:  alu_y = {{(`MIPS_WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
			`MIPS_ALU_SLTU: alu_y = {{(`MIPS_WORD_W-1){1'b0}}, a < b};
			`MIPS_ALU_SLL:  alu_y = b << sh;
			`MIPS_ALU_SRL:  alu_y = b >> sh;
			`MIPS_ALU_SRA:  alu_y = $signed(b) >>> sh;
			default:        alu_y = '0;
		endcase
	end

	always_comb begin
		ex_result_o.wreg = id_ex_i.wreg;
		ex_result_o.wd = id_ex_i.wd;
		ex_result_o.wdata = id_ex_i.illegal ? '0 : alu_y;
		ex_result_o.illegal = id_ex_i.illegal;
	end

	always_comb begin
		ex_fwd_o.wreg = id_ex_valid_i && id_ex_i.wreg;
		ex_fwd_o.wd = id_ex_i.wd;
		ex_fwd_o.wdata = alu_y;
	end

	assign ex_valid_o = id_ex_valid_i;

endmodule

// File: hdl/wb_stage.sv
`timescale 1ns/100ps

module wb_stage
	import mips_pipe_pkg::*;
(
	input logic clk_i,
	input logic reset_i,
	input logic advance_i,
	input logic ex_valid_i,
	input result_t ex_result_i,
	input logic result_ready_i,
	output logic result_valid_o,
	output result_t result_o,
	output fwd_t wb_fwd_o,
	output fwd_t reg_wr_o,
	output logic full_o
);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			result_valid_o <= 1'b0;
		end else if (advance_i) begin
			result_valid_o <= ex_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (advance_i) begin
			result_o <= ex_result_i;
		end
	end

	assign full_o = result_valid_o;

	always_comb begin
		wb_fwd_o.wreg = result_valid_o && result_o.wreg;
		wb_fwd_o.wd = result_o.wd;
		wb_fwd_o.wdata = result_o.wdata;
		// Commit only when the item is handed off
		reg_wr_o.wreg = result_valid_o && result_ready_i && result_o.wreg;
		reg_wr_o.wd = result_o.wd;
		reg_wr_o.wdata = result_o.wdata;
	end

endmodule

// File: hdl/mips_decode_core.sv
`timescale 1ns/100ps

module mips_decode_core
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
(
	input logic clk_i,
	input logic reset_i,
	input logic inst_valid_i,
	input inst_t inst_i,
	output logic inst_ready_o,
	output logic result_valid_o,
	output result_t result_o,
	input logic result_ready_i
);

	logic advance;
	logic wb_full;
	logic id_ex_valid;
	logic ex_valid;
	id_ex_t id_ex;
	fwd_t ex_fwd;
	fwd_t wb_fwd;
	fwd_t reg_wr;
	result_t ex_result;
	reg_addr_t rd1_addr;
	reg_addr_t rd2_addr;
	word_t rd1_data;
	word_t rd2_data;

	assign advance = !wb_full || result_ready_i; // Whole pipe moves together
	assign inst_ready_o = advance;

	id_stage u_id (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.advance_i(advance),
		.inst_valid_i(inst_valid_i),
		.inst_i(inst_i),
		.ex_fwd_i(ex_fwd),
		.wb_fwd_i(wb_fwd),
		.rd1_addr_o(rd1_addr),
		.rd2_addr_o(rd2_addr),
		.rd1_data_i(rd1_data),
		.rd2_data_i(rd2_data),
		.id_ex_valid_o(id_ex_valid),
		.id_ex_o(id_ex)
	);

	reg_file u_rf (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.wr_i(reg_wr),
		.rd1_addr_i(rd1_addr),
		.rd2_addr_i(rd2_addr),
		.rd1_data_o(rd1_data),
		.rd2_data_o(rd2_data)
	);

	ex_stage u_ex (
		.id_ex_valid_i(id_ex_valid),
		.id_ex_i(id_ex),
		.ex_fwd_o(ex_fwd),
		.ex_valid_o(ex_valid),
		.ex_result_o(ex_result)
	);

	wb_stage u_wb (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.advance_i(advance),
		.ex_valid_i(ex_valid),
		.ex_result_i(ex_result),
		.result_ready_i(result_ready_i),
		.result_valid_o(result_valid_o),
		.result_o(result_o),
		.wb_fwd_o(wb_fwd),
		.reg_wr_o(reg_wr),
		.full_o(wb_full)
	);

endmodule

// File: dv/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

word_t shadow [32]; // Architectural register state seen so far

function automatic inst_t encode_r(input funct_t fn, input reg_addr_t rd, input reg_addr_t rs,
	input reg_addr_t rt, input shamt_t sa);
	return {`MIPS_OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic inst_t encode_i(input opcode_t op, input reg_addr_t rt, input reg_addr_t rs,
	input imm16_t imm);
	return {op, rs, rt, imm};
endfunction

// Expected item from the ISA rules and the shadow registers
function automatic result_t expect_result(input inst_t inst);
	result_t r;
	reg_addr_t rs;
	reg_addr_t rt;
	shamt_t sa;
	word_t a;
	word_t b;
	word_t zimm;
	word_t simm;
	logic legal;
	rs = inst[25:21];
	rt = inst[20:16];
	sa = inst[10:6];
	a = shadow[rs];
	b = shadow[rt];
	zimm = {16'h0000, inst[15:0]};
	simm = {{16{inst[15]}}, inst[15:0]};
	r = '0;
	r.wd = rt;
	legal = 1'b1;
	case (inst[31:26])
		`MIPS_OP_SPECIAL: begin
			r.wd = inst[15:11];
			legal = (sa == '0);
			case (inst[5:0])
				`MIPS_FN_OR:   r.wdata = a | b;
				`MIPS_FN_AND:  r.wdata = a & b;
				`MIPS_FN_XOR:  r.wdata = a ^ b;
				`MIPS_FN_NOR:  r.wdata = ~(a | b);
				`MIPS_FN_ADDU: r.wdata = a + b;
				`MIPS_FN_SUBU: r.wdata = a - b;
				`MIPS_FN_SLT:  r.wdata = {31'b0, $signed(a) < $signed(b)};
				`MIPS_FN_SLTU: r.wdata = {31'b0, a < b};
				`MIPS_FN_SLLV: r.wdata = b << a[4:0];
				`MIPS_FN_SRLV: r.wdata = b >> a[4:0];
				`MIPS_FN_SRAV: r.wdata = $signed(b) >>> a[4:0];
				`MIPS_FN_SLL: begin
					legal = (rs == '0);
					r.wdata = b << sa;
				end
				`MIPS_FN_SRL: begin
					legal = (rs == '0);
					r.wdata = b >> sa;
				end
				`MIPS_FN_SRA: begin
					legal = (rs == '0);
					r.wdata = $signed(b) >>> sa;
				end
				default: legal = 1'b0;
			endcase
		end
		`MIPS_OP_ORI:   r.wdata = a | zimm;
		`MIPS_OP_ANDI:  r.wdata = a & zimm;
		`MIPS_OP_XORI:  r.wdata = a ^ zimm;
		`MIPS_OP_LUI:   r.wdata = {inst[15:0], 16'h0000};
		`MIPS_OP_ADDIU: r.wdata = a + simm;
		`MIPS_OP_SLTI:  r.wdata = {31'b0, $signed(a) < $signed(simm)};
		`MIPS_OP_SLTIU: r.wdata = {31'b0, a < simm};
		default: legal = 1'b0;
	endcase
	if (!legal) begin
		r.wdata = '0;
	end
	r.illegal = !legal;
	r.wreg = legal && (r.wd != '0);
	return r;
endfunction

task automatic check_result();
	inst_t inst;
	result_t exp;
	if (sent_q.size() == 0) begin
		abort_run("Result item arrived with no instruction outstanding");
	end else begin
		inst = sent_q.pop_front();
		exp = expect_result(inst);
		if (exp.illegal) begin // Destination of an illegal item is not defined
			check_equal(64'(result_o.illegal), 64'd1, $sformatf("illegal flag, inst %h", inst));
			check_equal(64'(result_o.wreg), 64'd0, $sformatf("wreg, inst %h", inst));
			check_equal(64'(result_o.wdata), 64'd0, $sformatf("wdata, inst %h", inst));
		end else begin
			check_equal(64'(result_o), 64'(exp), $sformatf("result item, inst %h", inst));
		end
		if (exp.wreg) begin
			shadow[exp.wd] = exp.wdata;
		end
	end
endtask

function automatic inst_t random_inst();
	funct_t fns [14];
	opcode_t ops [7];
	int pick;
	reg_addr_t rd;
	reg_addr_t rs;
	reg_addr_t rt;
	shamt_t sa;
	fns = '{`MIPS_FN_OR, `MIPS_FN_AND, `MIPS_FN_XOR, `MIPS_FN_NOR, `MIPS_FN_ADDU,
		`MIPS_FN_SUBU, `MIPS_FN_SLT, `MIPS_FN_SLTU, `MIPS_FN_SLLV, `MIPS_FN_SRLV,
		`MIPS_FN_SRAV, `MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA};
	ops = '{`MIPS_OP_ORI, `MIPS_OP_ANDI, `MIPS_OP_XORI, `MIPS_OP_LUI, `MIPS_OP_ADDIU,
		`MIPS_OP_SLTI, `MIPS_OP_SLTIU};
	pick = {$random(seed)} % 21;
	rd = reg_addr_t'($random(seed) & 15); // Small set, so hazards are frequent
	rs = reg_addr_t'($random(seed) & 15);
	rt = reg_addr_t'($random(seed) & 15);
	sa = '0;
	if (pick >= 14) begin
		return encode_i(ops[pick - 14], rt, rs, imm16_t'($random(seed)));
	end
	if (pick >= 11) begin
		sa = shamt_t'($random(seed));
		rs = '0;
	end
	return encode_r(fns[pick], rd, rs, rt, sa);
endfunction

task automatic test_reset();
	for (int i = 0; i < 32; i++) begin
		shadow[i] = '0;
	end
	@(negedge clk_i);
	check_equal(64'(result_valid_o), 64'd0, "result_valid_o after reset");
	check_equal(64'(inst_ready_o), 64'd1, "inst_ready_o after reset");
	@(posedge clk_i);
	#1;
endtask

task automatic test_logic();
	batch_q.push_back(encode_i(`MIPS_OP_LUI, 5'd1, 5'd0, 16'h8421));
	batch_q.push_back(encode_i(`MIPS_OP_ORI, 5'd2, 5'd1, 16'h5a5a));
	batch_q.push_back(encode_i(`MIPS_OP_ANDI, 5'd3, 5'd2, 16'hff0f));
	batch_q.push_back(encode_i(`MIPS_OP_XORI, 5'd4, 5'd3, 16'h1234));
	batch_q.push_back(encode_r(`MIPS_FN_OR, 5'd5, 5'd4, 5'd1, 5'd0)); // r1 from the register file
	batch_q.push_back(encode_r(`MIPS_FN_AND, 5'd6, 5'd5, 5'd2, 5'd0));
	batch_q.push_back(encode_r(`MIPS_FN_XOR, 5'd7, 5'd6, 5'd5, 5'd0));
	batch_q.push_back(encode_r(`MIPS_FN_NOR, 5'd8, 5'd7, 5'd6, 5'd0));
	run_batch(1'b0);
endtask

task automatic test_arith();
	word_t value;
	for (int i = 0; i < 4; i++) begin
		value = $random(seed);
		batch_q.push_back(encode_i(`MIPS_OP_LUI, reg_addr_t'(9 + i), 5'd0, value[31:16]));
		batch_q.push_back(encode_i(`MIPS_OP_ORI, reg_addr_t'(9 + i), reg_addr_t'(9 + i),
			value[15:0]));
	end
	batch_q.push_back(encode_r(`MIPS_FN_ADDU, 5'd16, 5'd9, 5'd10, 5'd0));
	batch_q.push_back(encode_r(`MIPS_FN_SUBU, 5'd17, 5'd9, 5'd11, 5'd0));
	batch_q.push_back(encode_i(`MIPS_OP_ADDIU, 5'd18, 5'd10, imm16_t'($random(seed))));
	batch_q.push_back(encode_r(`MIPS_FN_SLT, 5'd19, 5'd9, 5'd10, 5'd0));
	batch_q.push_back(encode_r(`MIPS_FN_SLTU, 5'd20, 5'd11, 5'd12, 5'd0));
	batch_q.push_back(encode_i(`MIPS_OP_SLTI, 5'd21, 5'd12, imm16_t'($random(seed))));
	batch_q.push_back(encode_i(`MIPS_OP_SLTIU, 5'd22, 5'd9, imm16_t'($random(seed))));
	batch_q.push_back(encode_r(`MIPS_FN_SLL, 5'd23, 5'd0, 5'd10, shamt_t'($random(seed))));
	batch_q.push_back(encode_r(`MIPS_FN_SRL, 5'd24, 5'd0, 5'd11, shamt_t'($random(seed))));
	batch_q.push_back(encode_r(`MIPS_FN_SRA, 5'd25, 5'd0, 5'd12, shamt_t'($random(seed))));
	batch_q.push_back(encode_r(`MIPS_FN_SLLV, 5'd26, 5'd9, 5'd11, 5'd0));
	batch_q.push_back(encode_r(`MIPS_FN_SRLV, 5'd27, 5'd10, 5'd12, 5'd0));
	batch_q.push_back(encode_r(`MIPS_FN_SRAV, 5'd28, 5'd11, 5'd9, 5'd0));
	run_batch(1'b0);
endtask

task automatic test_backpressure();
	repeat (20) begin
		batch_q.push_back(random_inst());
	end
	run_batch(1'b1);
endtask

task automatic test_illegal();
	batch_q.push_back(encode_r(6'b011000, 5'd0, 5'd1, 5'd2, 5'd0)); // MULT
	batch_q.push_back(encode_r(6'b001111, 5'd0, 5'd0, 5'd0, 5'd0)); // SYNC
	batch_q.push_back(encode_r(6'b100000, 5'd5, 5'd1, 5'd2, 5'd0)); // ADD
	batch_q.push_back(encode_i(`MIPS_OP_ORI, 5'd0, 5'd1, 16'h00ff));
	batch_q.push_back(encode_r(`MIPS_FN_ADDU, 5'd13, 5'd0, 5'd2, 5'd0)); // r0 must read zero
	batch_q.push_back(encode_i(`MIPS_OP_ADDIU, 5'd14, 5'd0, 16'h0001));
	batch_q.push_back(encode_r(`MIPS_FN_OR, 5'd15, 5'd5, 5'd0, 5'd0)); // r5 untouched by ADD
	run_batch(1'b0);
endtask

task automatic test_latency();
	inst_t inst;
	inst = encode_i(`MIPS_OP_ADDIU, 5'd29, 5'd9, 16'h8001);
	result_ready_i = 1'b1;
	inst_valid_i = 1'b1;
	inst_i = inst;
	@(negedge clk_i);
	check_equal(64'(inst_ready_o), 64'd1, "inst_ready_o with an empty pipeline");
	sent_q.push_back(inst);
	@(posedge clk_i); // Accepted here
	#1;
	inst_valid_i = 1'b0;
	@(negedge clk_i);
	check_equal(64'(result_valid_o), 64'd0, "result_valid_o one edge after acceptance");
	@(negedge clk_i);
	check_equal(64'(result_valid_o), 64'd1, "result_valid_o two edges after acceptance");
	check_result();
	@(posedge clk_i);
	#1;
endtask

`endif

// File: dv/tb_top.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module tb_top
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;
();

	logic clk_i;
	logic reset_i;
	logic inst_valid_i;
	inst_t inst_i;
	logic inst_ready_o;
	logic result_valid_o;
	result_t result_o;
	logic result_ready_i;

	integer seed = 32'hcc2cc777;
	int error_count = 0;
	inst_t batch_q [$]; // Waiting to be sent
	inst_t sent_q [$]; // Accepted, result not yet checked

	initial begin
		clk_i = 1'b0;
		forever begin
			#2 clk_i = ~clk_i;
		end
	end

	mips_decode_core dut0 (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.inst_valid_i(inst_valid_i),
		.inst_i(inst_i),
		.inst_ready_o(inst_ready_o),
		.result_valid_o(result_valid_o),
		.result_o(result_o),
		.result_ready_i(result_ready_i)
	);

	task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t: %s: got %h, expected %h", $time, what, actual, expected);
			$display("TESTS FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%0t: %s", $time, why);
		$display("TESTS FAILED");
		$fatal(1, "run aborted");
	endtask

	// Called a little after a rising edge; returns at the same phase
	task automatic send_inst(input inst_t inst);
		int waited;
		waited = 0;
		inst_valid_i = 1'b1;
		inst_i = inst;
		@(negedge clk_i);
		while (!inst_ready_o) begin
			waited++;
			if (waited > 100) begin
				abort_run("Timeout: inst_ready_o stayed low");
			end
			@(negedge clk_i);
		end
		sent_q.push_back(inst); // Taken at the next edge
		@(posedge clk_i);
		#1;
		inst_valid_i = 1'b0;
	endtask

	task automatic send_all();
		while (batch_q.size() > 0) begin
			send_inst(batch_q.pop_front());
		end
	endtask

	task automatic collect_results(input int count, input bit random_ready);
		int got;
		int idle;
		int low_left;
		got = 0;
		idle = 0;
		low_left = 0;
		while (got < count) begin
			if (random_ready && low_left > 0) begin
				result_ready_i = 1'b0;
				low_left--;
			end else begin
				result_ready_i = 1'b1;
			end
			@(negedge clk_i);
			if (result_valid_o && result_ready_i) begin
				check_result();
				got++;
				idle = 0;
				if (random_ready) begin
					low_left = {$random(seed)} % 5;
				end
			end else begin
				idle++;
				if (idle > 100) begin
					abort_run("Timeout: no result item arrived");
				end
			end
			@(posedge clk_i);
			#1;
		end
		result_ready_i = 1'b1;
	endtask

	task automatic run_batch(input bit random_ready);
		int count;
		count = batch_q.size();
		fork
			send_all();
			collect_results(count, random_ready);
		join
		@(negedge clk_i);
		check_equal(64'(result_valid_o), 64'd0, "extra result item after the batch");
		@(posedge clk_i);
		#1;
	endtask

	`include "tb_tests.svh"

	initial begin
		reset_i = 1'b1;
		inst_valid_i = 1'b0;
		inst_i = '0;
		result_ready_i = 1'b1;
		repeat (16) @(posedge clk_i);
		#1;
		reset_i = 1'b0;

		test_reset();
		test_logic();
		test_arith();
		test_backpressure();
		test_illegal();
		test_latency();

		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+hdl
+incdir+dv
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/inst_decoder.sv
hdl/id_stage.sv
hdl/reg_file.sv
hdl/ex_stage.sv
hdl/wb_stage.sv
hdl/mips_decode_core.sv
dv/tb_top.sv

// File: Makefile
TOP := tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module mips_decode_core

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
